/* Makefile */
OBJ_DIR := obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_armReducedCore -Mdir $(OBJ_DIR) -o tb_armReducedCore

# the simulator exits with a failing status when the testbench stops on $fatal.
run: compile
	./$(OBJ_DIR)/tb_armReducedCore

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+logic
logic/armIsaPkg.sv
logic/busPkg.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/controlFsm.sv
logic/axilMaster.sv
logic/armReducedCore.sv
testbench/tb_armReducedCore.sv

/* logic/aluUnit.sv */
`timescale 1ns/10ps

module aluUnit import armIsaPkg::*; (
    input  aluOpE i_op,
    input  wordT  i_opA,
    input  wordT  i_opB,
    output wordT  o_result,
    output flagsT o_flags
);

    logic [$bits(wordT):0] sum;
    logic [$bits(wordT):0] diff;
    wordT result;
    logic carry;

    assign sum = {1'b0, i_opA} + {1'b0, i_opB};

    // a - b is built as a + ~b + 1, so the top bit is set when no borrow occurs.
    assign diff = {1'b0, i_opA} + {1'b0, ~i_opB} + 1'b1;

    always_comb begin
        result = '0;
        carry = 1'b0;
        case (i_op)
            OP_AND: begin
                result = i_opA & i_opB;
            end
            OP_ORR: begin
                result = i_opA | i_opB;
            end
            OP_MOV: begin
                result = i_opB;
            end
            OP_ADD: begin
                result = sum[$bits(wordT)-1:0];
                carry = sum[$bits(wordT)];
            end
            OP_SUB, OP_CMP: begin
                // cmp produces the same difference, the control FSM just never writes it back.
                result = diff[$bits(wordT)-1:0];
                carry = diff[$bits(wordT)];
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign o_result = result;
    assign o_flags.z = (result == '0);
    assign o_flags.c = carry;

endmodule

/* logic/armIsaPkg.sv */
package armIsaPkg;

`include "core_params.svh"

    typedef logic [`DATA_WIDTH-1:0] wordT;
    typedef logic [`ADDR_WIDTH-1:0] addrT;
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;
    typedef logic [4:0] shamtT;
    typedef logic [11:0] imm12T;

    typedef enum logic [3:0] {
        COND_EQ = 4'b0000,
        COND_NE = 4'b0001,
        COND_AL = 4'b1110
    } condE;

    // bits 27:26 of the instruction.
    typedef enum logic [1:0] {
        CLS_DATA   = 2'b00,
        CLS_MEM    = 2'b01,
        CLS_BRANCH = 2'b10
    } instrClassE;

    typedef enum logic [3:0] {
        OP_AND = 4'b0000,
        OP_SUB = 4'b0010,
        OP_ADD = 4'b0100,
        OP_CMP = 4'b1010,
        OP_ORR = 4'b1100,
        OP_MOV = 4'b1101
    } aluOpE;

    // data-processing and load/store layout. load is the S bit for data processing.
    typedef struct packed {
        condE       cond;
        instrClassE cls;
        logic       imm;
        aluOpE      opcode;
        logic       load;
        regIdxT     rn;
        regIdxT     rd;
        imm12T      operand;
    } instrT;

    typedef struct packed {
        logic z;
        logic c;
    } flagsT;

    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        EXECUTE,
        ALUWB,
        MEMADDR,
        MEMREAD,
        MEMWB,
        MEMWRITE,
        BRANCH
    } ctrlStateE;

endpackage

/* logic/armReducedCore.sv */
`timescale 1ns/10ps

`include "core_params.svh"

module armReducedCore import armIsaPkg::*, busPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  axilRspT i_axil,
    output axilReqT o_axil
);

    wordT ir;
    instrT irFields;
    addrT instrAddr;
    wordT regA;
    wordT regB;
    wordT aluOut;
    wordT mdr;
    flagsT flags;
    flagsT aluFlags;
    memReqT memReq;
    memRspT memRsp;
    logic irWrite;
    logic regWrite;
    logic flagWrite;
    logic writeSel;
    logic opBSel;
    logic pcWrite;
    aluOpE aluOp;
    wordT readA;
    wordT readB;
    wordT pc;
    wordT aluResult;
    wordT opB;
    wordT immExt;
    wordT branchOffset;
    wordT pcAhead;
    wordT writeData;
    regIdxT readIdxB;
    regIdxT writeIdx;
    shamtT shamt;

    assign irFields = instrT'(ir);
    assign shamt = irFields.operand[11:7];

    // a store reads its data from Rd, data processing reads Rm.
    assign readIdxB = (irFields.cls == CLS_MEM) ? irFields.rd : irFields.operand[3:0];

    assign pcAhead = instrAddr + wordT'(`PC_AHEAD);
    assign immExt = wordT'(irFields.operand);
    assign branchOffset = {{(`DATA_WIDTH-26){ir[23]}}, ir[23:0], 2'b00};
    assign opB = opBSel ? immExt : (regB << shamt);

    assign writeIdx = pcWrite ? regIdxT'(`PC_REG) : irFields.rd;
    always_comb begin
        if (pcWrite) begin
            writeData = writeSel ? (pcAhead + branchOffset) : (pc + wordT'(4));
        end else begin
            writeData = writeSel ? mdr : aluOut;
        end
    end

    // instrAddr keeps the fetch address, since r15 moves on during DECODE.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ir <= '0;
            instrAddr <= addrT'(`RESET_PC);
            flags <= '0;
        end else begin
            if (irWrite) begin
                ir <= memRsp.rdata;
                instrAddr <= pc;
            end
            if (flagWrite) begin
                flags <= aluFlags;
            end
        end
    end

    always_ff @(posedge clk) begin
        regA <= (irFields.rn == regIdxT'(`PC_REG)) ? pcAhead : readA;
        regB <= (readIdxB == regIdxT'(`PC_REG)) ? pcAhead : readB;
        aluOut <= aluResult;
        if (memRsp.done) begin
            mdr <= memRsp.rdata;
        end
    end

    registerFile u_registerFile (
        .clk(clk), .reset(reset),
        .i_readIdxA(irFields.rn), .i_readIdxB(readIdxB),
        .i_writeIdx(writeIdx), .i_writeData(writeData),
        .i_writeEnable(regWrite || pcWrite),
        .o_readA(readA), .o_readB(readB), .o_pc(pc)
    );

    aluUnit u_aluUnit (
        .i_op(aluOp), .i_opA(regA), .i_opB(opB),
        .o_result(aluResult), .o_flags(aluFlags)
    );

    controlFsm u_controlFsm (
        .clk(clk), .reset(reset),
        .i_instr(ir), .i_flags(flags), .i_pc(pc),
        .i_aluOut(aluOut), .i_storeData(regB), .i_memRsp(memRsp),
        .o_memReq(memReq), .o_irWrite(irWrite), .o_regWrite(regWrite),
        .o_flagWrite(flagWrite), .o_writeSel(writeSel), .o_opBSel(opBSel),
        .o_aluOp(aluOp), .o_pcWrite(pcWrite)
    );

    axilMaster u_axilMaster (
        .clk(clk), .reset(reset),
        .i_memReq(memReq), .i_axil(i_axil),
        .o_memRsp(memRsp), .o_axil(o_axil)
    );

endmodule

/* logic/axilMaster.sv */
`timescale 1ns/10ps

module axilMaster import armIsaPkg::*, busPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  memReqT  i_memReq,
    input  axilRspT i_axil,
    output memRspT  o_memRsp,
    output axilReqT o_axil
);

    typedef enum logic [2:0] {
        AX_IDLE,
        AX_RADDR,
        AX_RDATA,
        AX_WRITE,
        AX_BRESP,
        AX_DONE
    } axStateE;

    axStateE state;
    logic awvalid;
    logic wvalid;
    logic bready;
    logic arvalid;
    logic rready;
    addrT addr;
    wordT wdata;
    wordT rdata;
    logic awDone;
    logic wDone;

    // aw and w are accepted independently; both must be through before the response.
    assign awDone = !awvalid || i_axil.awready;
    assign wDone = !wvalid || i_axil.wready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= AX_IDLE;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            bready <= 1'b0;
            arvalid <= 1'b0;
            rready <= 1'b0;
        end else begin
            case (state)
                AX_IDLE: begin
                    if (i_memReq.valid && i_memReq.write) begin
                        awvalid <= 1'b1;
                        wvalid <= 1'b1;
                        state <= AX_WRITE;
                    end else if (i_memReq.valid) begin
                        arvalid <= 1'b1;
                        state <= AX_RADDR;
                    end
                end
                AX_RADDR: begin
                    if (i_axil.arready) begin
                        arvalid <= 1'b0;
                        rready <= 1'b1;
                        state <= AX_RDATA;
                    end
                end
                AX_RDATA: begin
                    if (i_axil.rvalid) begin
                        rready <= 1'b0;
                        state <= AX_DONE;
                    end
                end
                AX_WRITE: begin
                    if (i_axil.awready) begin
                        awvalid <= 1'b0;
                    end
                    if (i_axil.wready) begin
                        wvalid <= 1'b0;
                    end
                    if (awDone && wDone) begin
                        bready <= 1'b1;
                        state <= AX_BRESP;
                    end
                end
                AX_BRESP: begin
                    if (i_axil.bvalid) begin
                        bready <= 1'b0;
                        state <= AX_DONE;
                    end
                end
                default: state <= AX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == AX_IDLE && i_memReq.valid) begin
            addr <= i_memReq.addr;
            wdata <= i_memReq.wdata;
        end
        if (state == AX_RDATA && i_axil.rvalid) begin
            rdata <= i_axil.rdata;
        end
    end

    assign o_memRsp = '{done: (state == AX_DONE), rdata: rdata};

    assign o_axil = '{
        awvalid: awvalid,
        awaddr:  addr,
        wvalid:  wvalid,
        wdata:   wdata,
        wstrb:   '1,
        bready:  bready,
        arvalid: arvalid,
        araddr:  addr,
        rready:  rready
    };

    arHeld: assert property (@(posedge clk) disable iff (reset)
        (arvalid && !i_axil.arready) |=> arvalid);
    awHeld: assert property (@(posedge clk) disable iff (reset)
        (awvalid && !i_axil.awready) |=> awvalid);
    wHeld: assert property (@(posedge clk) disable iff (reset)
        (wvalid && !i_axil.wready) |=> wvalid);
    noMixedTraffic: assert property (@(posedge clk) disable iff (reset)
        !((arvalid || rready) && (awvalid || wvalid || bready)));

endmodule

/* logic/busPkg.sv */
package busPkg;

    import armIsaPkg::*;

`include "core_params.svh"

    typedef logic [`DATA_WIDTH/8-1:0] strbT;
    typedef logic [1:0] respT;

    // one outstanding access between the control FSM and the bus master.
    typedef struct packed {
        logic valid;
        logic write;
        addrT addr;
        wordT wdata;
    } memReqT;

    typedef struct packed {
        logic done;
        wordT rdata;
    } memRspT;

    typedef struct packed {
        logic awvalid;
        addrT awaddr;
        logic wvalid;
        wordT wdata;
        strbT wstrb;
        logic bready;
        logic arvalid;
        addrT araddr;
        logic rready;
    } axilReqT;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        respT bresp;
        logic arready;
        logic rvalid;
        wordT rdata;
        respT rresp;
    } axilRspT;

endpackage

/* logic/controlFsm.sv */
`timescale 1ns/10ps

module controlFsm import armIsaPkg::*, busPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  wordT   i_instr,
    input  flagsT  i_flags,
    input  wordT   i_pc,
    input  wordT   i_aluOut,
    input  wordT   i_storeData,
    input  memRspT i_memRsp,
    output memReqT o_memReq,
    output logic   o_irWrite,
    output logic   o_regWrite,
    output logic   o_flagWrite,
    output logic   o_writeSel,
    output logic   o_opBSel,
    output aluOpE  o_aluOp,
    output logic   o_pcWrite
);

    ctrlStateE state;
    ctrlStateE nextState;
    instrT instr;
    logic condPass;
    logic isMem;
    logic isCmp;
    logic reqValid;

    assign instr = instrT'(i_instr);
    assign isMem = (instr.cls == CLS_MEM);
    assign isCmp = (instr.opcode == OP_CMP);

    // only the Z flag is tested.
    always_comb begin
        case (instr.cond)
            COND_EQ: condPass = i_flags.z;
            COND_NE: condPass = ~i_flags.z;
            COND_AL: condPass = 1'b1;
            default: condPass = 1'b0;
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            FETCH: begin
                if (i_memRsp.done) begin
                    nextState = DECODE;
                end
            end
            DECODE: begin
                if (!condPass) begin
                    nextState = FETCH;
                end else begin
                    case (instr.cls)
                        CLS_DATA:   nextState = EXECUTE;
                        CLS_MEM:    nextState = MEMADDR;
                        CLS_BRANCH: nextState = BRANCH;
                        default:    nextState = FETCH;
                    endcase
                end
            end
            EXECUTE: nextState = ALUWB;
            MEMADDR: nextState = instr.load ? MEMREAD : MEMWRITE;
            MEMREAD: begin
                if (i_memRsp.done) begin
                    nextState = MEMWB;
                end
            end
            MEMWRITE: begin
                if (i_memRsp.done) begin
                    nextState = FETCH;
                end
            end
            default: nextState = FETCH;
        endcase
    end

    // valid is registered, so it is low for the cycle after every done,
    // including the store that goes straight back to FETCH.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
            reqValid <= 1'b0;
        end else begin
            state <= nextState;
            reqValid <= (nextState inside {FETCH, MEMREAD, MEMWRITE}) && !i_memRsp.done;
        end
    end

    // only a store carries data, so a fetch right after a register writeback
    // keeps a steady request.
    assign o_memReq = '{
        valid: reqValid,
        write: (state == MEMWRITE),
        addr:  (state == FETCH) ? i_pc : i_aluOut,
        wdata: (state == MEMWRITE) ? i_storeData : '0
    };

    assign o_irWrite = (state == FETCH) && i_memRsp.done;
    assign o_regWrite = ((state == ALUWB) && !isCmp) || (state == MEMWB);
    assign o_flagWrite = (state == EXECUTE) && isCmp;
    assign o_pcWrite = (state == DECODE) || (state == BRANCH);

    // with pcWrite, 1 picks the branch target over PC+4. otherwise 1 picks the MDR.
    assign o_writeSel = (state == MEMWB) || (state == BRANCH);

    // decoded from the instruction alone, so ALU-out stays put across memory waits.
    assign o_opBSel = isMem || instr.imm;
    assign o_aluOp = isMem ? OP_ADD : instr.opcode;

    reqStableUntilDone: assert property (@(posedge clk) disable iff (reset)
        (o_memReq.valid && !i_memRsp.done) |=> $stable(o_memReq));

endmodule

/* logic/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// width of a data word and of a byte address.
`define DATA_WIDTH 32
`define ADDR_WIDTH 32

// architectural register file.
`define REG_COUNT 16

// r15 doubles as the program counter.
`define PC_REG 15

// address of the first instruction fetched after reset.
`define RESET_PC 0

// reading r15 as an operand, or using it as a branch base, yields
// the address of the current instruction plus this amount.
`define PC_AHEAD 8

`endif

/* logic/registerFile.sv */
`timescale 1ns/10ps

`include "core_params.svh"

module registerFile import armIsaPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  regIdxT i_readIdxA,
    input  regIdxT i_readIdxB,
    input  regIdxT i_writeIdx,
    input  wordT   i_writeData,
    input  logic   i_writeEnable,
    output wordT   o_readA,
    output wordT   o_readB,
    output wordT   o_pc
);

    wordT regs [`REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= (i == `PC_REG) ? wordT'(`RESET_PC) : '0;
            end
        end else if (i_writeEnable) begin
            regs[i_writeIdx] <= i_writeData;
        end
    end

    assign o_readA = regs[i_readIdxA];
    assign o_readB = regs[i_readIdxB];

    // the program counter lives in r15.
    assign o_pc = regs[`PC_REG];

    // the write index comes from the instruction or the PC select in the core,
    // and an unknown index would land on no register at all.
    writeIdxKnown: assert property (@(posedge clk) disable iff (reset)
        i_writeEnable |-> !$isunknown(i_writeIdx))
        else $error("register write to index %0d", i_writeIdx);

endmodule

/* testbench/tb_armReducedCore.sv */
`timescale 1ns/10ps

`include "core_params.svh"

module tb_armReducedCore import armIsaPkg::*, busPkg::*; ();

    logic clk = 1'b0;
    logic reset;
    axilRspT axilRsp;
    axilReqT axilReq;

    wordT mem [addrT];
    addrT expAddr [$];
    wordT expData [$];
    int progLines = 0;
    int storeLines = 0;
    int storesSeen = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    logic [7:0] lfsr = 8'd56;
    logic readSeen = 1'b0;

    armReducedCore u_armReducedCore (
        .clk(clk),
        .reset(reset),
        .i_axil(axilRsp),
        .o_axil(axilReq)
    );

    always #5 clk = ~clk;

    task automatic abortRun();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkAddr(addrT actual, addrT expected, string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkData(wordT actual, wordT expected, string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkStrobe(strbT actual, strbT expected, string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkIdleBus(string when);
        if (axilReq.arvalid || axilReq.awvalid || axilReq.wvalid
                || axilReq.rready || axilReq.bready) begin
            $display("an AXI valid or ready is high %s", when);
            abortRun();
        end
    endtask

    // 8-bit Galois LFSR, taps for x^8 + x^6 + x^5 + x^4 + 1.
    function automatic logic [7:0] lfsrStep(logic [7:0] state);
        return (state >> 1) ^ (state[0] ? 8'hB8 : 8'h00);
    endfunction

    function automatic int nextDelay();
        logic [2:0] value;
        value = '0;
        for (int i = 0; i < 3; i++) begin
            value = {value[1:0], lfsr[0]};
            lfsr = lfsrStep(lfsr);
        end
        return int'(value);
    endfunction

    // unwritten locations read back as the inverted address.
    function automatic wordT readWord(addrT addr);
        return mem.exists(addr) ? mem[addr] : ~addr;
    endfunction

    task automatic waitCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic loadTestData();
        int fd;
        int status;
        int fields;
        string line;
        logic [7:0] kind;
        addrT addr;
        wordT data;
        fd = $fopen("testbench/testdata_program.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/testdata_program.txt");
            abortRun();
        end else begin
            while (!$feof(fd)) begin
                status = $fgets(line, fd);
                fields = (status > 0) ? $sscanf(line, "%c %h %h", kind, addr, data) : 0;
                if (fields == 3 && kind == "P") begin
                    mem[addr] = data;
                    progLines++;
                end else if (fields == 3 && kind == "E") begin
                    expAddr.push_back(addr);
                    expData.push_back(data);
                    storeLines++;
                end
            end
            $fclose(fd);
            cycleLimit = 40 * (progLines + storeLines) + 200;
        end
    endtask

    task automatic recordStore(addrT addr, wordT data);
        mem[addr] = data;
        if (expAddr.size() == 0) begin
            $display("MISMATCH at %0t ns: store of %h to %h after the expected list ended",
                $time, data, addr);
            abortRun();
        end else begin
            checkAddr(addr, expAddr.pop_front(), "store address");
            checkData(data, expData.pop_front(), "store data");
            storesSeen++;
        end
    endtask

    task automatic serveRead();
        addrT addr;
        logic taken;
        addr = axilReq.araddr;
        if (!readSeen) begin
            checkAddr(addr, addrT'(`RESET_PC), "first read address");
            readSeen = 1'b1;
        end
        repeat (nextDelay()) waitCycle();
        axilRsp.arready = 1'b1;
        do begin
            taken = axilReq.arvalid;
            waitCycle();
        end while (!taken);
        axilRsp.arready = 1'b0;
        repeat (nextDelay()) waitCycle();
        axilRsp.rdata = readWord(addr);
        axilRsp.rresp = 2'b00;
        axilRsp.rvalid = 1'b1;
        do begin
            taken = axilReq.rready;
            waitCycle();
        end while (!taken);
        axilRsp.rvalid = 1'b0;
    endtask

    task automatic serveWrite();
        addrT addr;
        wordT data;
        int awWait;
        int wWait;
        logic awOpen;
        logic wOpen;
        logic awHit;
        logic wHit;
        logic taken;
        addr = axilReq.awaddr;
        data = axilReq.wdata;
        checkStrobe(axilReq.wstrb, '1, "write strobe");
        awWait = nextDelay();
        wWait = nextDelay();
        awOpen = 1'b1;
        wOpen = 1'b1;
        // the address and data channels are accepted on independent delays.
        while (awOpen || wOpen) begin
            axilRsp.awready = awOpen && (awWait == 0);
            axilRsp.wready = wOpen && (wWait == 0);
            awHit = axilRsp.awready && axilReq.awvalid;
            wHit = axilRsp.wready && axilReq.wvalid;
            waitCycle();
            if (awHit) begin
                awOpen = 1'b0;
            end else if (awWait > 0) begin
                awWait--;
            end
            if (wHit) begin
                wOpen = 1'b0;
            end else if (wWait > 0) begin
                wWait--;
            end
        end
        axilRsp.awready = 1'b0;
        axilRsp.wready = 1'b0;
        repeat (nextDelay()) waitCycle();
        axilRsp.bresp = 2'b00;
        axilRsp.bvalid = 1'b1;
        do begin
            taken = axilReq.bready;
            waitCycle();
        end while (!taken);
        axilRsp.bvalid = 1'b0;
        recordStore(addr, data);
    endtask

    initial begin
        axilRsp = '0;
        @(negedge reset);
        forever begin
            waitCycle();
            if (axilReq.arvalid) begin
                serveRead();
            end else if (axilReq.awvalid || axilReq.wvalid) begin
                serveWrite();
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles with %0d of %0d stores seen",
                cycleCount, storesSeen, storeLines);
            abortRun();
        end
    end

    initial begin
        reset = 1'b1;
        loadTestData();
        repeat (5) begin
            waitCycle();
            checkIdleBus("during reset");
        end
        reset = 1'b0;
        waitCycle();
        checkIdleBus("right after reset");
        wait (storesSeen == storeLines);
        // the program parks in a branch to itself, so no further store may follow.
        repeat (50) waitCycle();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* testbench/testdata_program.txt */
# P <byte address> <instruction or data word>  preloads the memory
# E <byte address> <data word>  is the next store the core must issue, in program order
P 00000000 E3A09100  # mov r9, #0x100
P 00000004 E3A015A3  # mov r1, #0x5a3
P 00000008 E281202D  # add r2, r1, #0x2d
P 0000000C E0423201  # sub r3, r2, r1, lsl #4
P 00000010 E5892000  # str r2, [r9]
P 00000014 E5893004  # str r3, [r9, #4]
P 00000018 E2034FF0  # and r4, r3, #0xff0
P 0000001C E1845401  # orr r5, r4, r1, lsl #8
P 00000020 E1A06185  # mov r6, r5, lsl #3
P 00000024 E5894008  # str r4, [r9, #8]
P 00000028 E589500C  # str r5, [r9, #12]
P 0000002C E5896010  # str r6, [r9, #16]
P 00000030 E5997004  # ldr r7, [r9, #4]
P 00000034 E5897014  # str r7, [r9, #20]
P 00000038 E1570003  # cmp r7, r3
P 0000003C 1A000001  # bne 0x4c, not taken
P 00000040 E3A080A1  # mov r8, #0xa1
P 00000044 E5898018  # str r8, [r9, #24]
P 00000048 0A000000  # beq 0x50, taken
P 0000004C E589101C  # str r1, [r9, #28], wrong path
P 00000050 E3570000  # cmp r7, #0
P 00000054 0AFFFFFC  # beq 0x4c, not taken
P 00000058 1A000000  # bne 0x60, taken
P 0000005C E589101C  # str r1, [r9, #28], wrong path
P 00000060 E3A080B2  # mov r8, #0xb2
P 00000064 E589801C  # str r8, [r9, #28]
P 00000068 03A08777  # moveq r8, #0x777, condition fails
P 0000006C E5898020  # str r8, [r9, #32]
P 00000070 05891024  # streq r1, [r9, #36], condition fails
P 00000074 E3A0A000  # mov r10, #0
P 00000078 E3A0B003  # mov r11, #3
P 0000007C E28AA001  # add r10, r10, #1
P 00000080 E24BB001  # sub r11, r11, #1
P 00000084 E35B0000  # cmp r11, #0
P 00000088 1AFFFFFB  # bne 0x7c
P 0000008C E589A024  # str r10, [r9, #36]
P 00000090 E28FC000  # add r12, r15, #0
P 00000094 E589C028  # str r12, [r9, #40]
P 00000098 EAFFFFFE  # b 0x98
E 00000100 000005D0
E 00000104 FFFFABA0
E 00000108 00000BA0
E 0000010C 0005ABA0
E 00000110 002D5D00
E 00000114 FFFFABA0
E 00000118 000000A1
E 0000011C 000000B2
E 00000120 000000B2
E 00000124 00000003
E 00000128 00000098
